/* Makefile */
# Verilator build and run of the MIF reconfiguration engine testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f xcvr_mif_reconfig.f \
		--top-module tb_mif_reconfig -Mdir obj_dir
	./obj_dir/Vtb_mif_reconfig

clean:
	rm -rf obj_dir

/* include/mif_params.svh */
/*
 * Widths and register map of the MIF reconfiguration engine.
 * Included by the type package and by every block that decodes addresses.
 */
`ifndef MIF_PARAMS_SVH
`define MIF_PARAMS_SVH

// Bus widths
`define MIF_WORD_W   16
`define MIF_ADDR_W   32
`define BASE_ADDR_W  3
`define REG_DATA_W   32
`define REC_CNT_W    16

// User register map
`define REG_CTRL     3'd0
`define REG_START    3'd1
`define REG_STATUS   3'd2
`define REG_COUNT    3'd3

// Record format
// Header bit that flags the last record of the MIF
`define REC_END_BIT  15

`endif

/* tests/mif_reconfig_chk.sv */
/*
 * Protocol checker for the MIF engine top level.
 * Bound into mif_reconfig_top to watch the stream, basic port and arbiter levels.
 */
`timescale 1ns/1ps

module mif_reconfig_chk
   import mif_bus_pkg::*;
(
   input logic        reconfig_clk,
   input logic        rst_n,
   input stream_req_s stream_req,
   input logic        mif_stream_waitrequest,
   input base_req_s   base_req,
   input logic        mif_base_waitrequest,
   input logic        arb_req,
   input logic        arb_grant,
   input logic        mif_reconfig_waitrequest,
   input logic        mif_reconfig_done
);

   ////////////////////////////////////////
   // Request stability under stall
   ////////////////////////////////////////

   // ROM read held until accepted
   stream_hold: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
      stream_req.read && mif_stream_waitrequest |=>
         stream_req.read && $stable(stream_req.address))
      else $error("ROM read request changed while stalled");

   // Basic port write held until accepted
   base_hold: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
      base_req.write && mif_base_waitrequest |=>
         base_req.write && $stable(base_req.address) && $stable(base_req.writedata))
      else $error("basic port write changed while stalled");

   ////////////////////////////////////////
   // Arbiter and idle state
   ////////////////////////////////////////

   write_granted: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
      base_req.write |-> arb_grant)
      else $error("basic port write without arbiter grant");

   // Done never high while the port is requested
   req_not_done: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
      arb_req |-> !mif_reconfig_done)
      else $error("done high while arb_req is high");

   // First cycle out of reset
   quiet_after_reset: assert property (@(posedge reconfig_clk)
      $rose(rst_n) |-> !stream_req.read && !base_req.write && !arb_req &&
         !mif_reconfig_waitrequest && mif_reconfig_done)
      else $error("outputs not idle after reset");

endmodule

bind mif_reconfig_top mif_reconfig_chk u_chk (
   .reconfig_clk             (reconfig_clk),
   .rst_n                    (rst_n),
   .stream_req               (stream_req),
   .mif_stream_waitrequest   (mif_stream_waitrequest),
   .base_req                 (base_req),
   .mif_base_waitrequest     (mif_base_waitrequest),
   .arb_req                  (arb_req),
   .arb_grant                (arb_grant),
   .mif_reconfig_waitrequest (mif_reconfig_waitrequest),
   .mif_reconfig_done        (mif_reconfig_done)
);

/* tests/tb_mif_reconfig.sv */
/*
 * Testbench of the MIF reconfiguration engine.
 * Models the MIF ROM, the basic block and the arbiter, runs two MIF regions
 * and compares the basic block registers and record count with the ROM image.
 */
`timescale 1ns/1ps
`include "mif_params.svh"

module tb_mif_reconfig
   import mif_types_pkg::*;
   import mif_bus_pkg::*;
();

   logic        reconfig_clk;
   logic        rst_n;
   user_req_s   user_req;
   reg_data_t   mif_reconfig_readdata;
   logic        mif_reconfig_waitrequest;
   logic        mif_reconfig_done;
   stream_req_s stream_req;
   logic        mif_stream_waitrequest = 1'b1;
   mif_word_t   mif_stream_readdata = '0;
   base_req_s   base_req;
   logic        mif_base_waitrequest = 1'b1;
   logic        arb_req;
   logic        arb_grant = 1'b0;

   // Models and expected image
   mif_word_t   rom [0:63];
   reg_data_t   base_regs [0:7];
   reg_data_t   exp_regs [0:7];
   int          exp_count;
   int          write_count = 0;
   logic [3:0]  grant_wait = '0;
   logic [3:0]  grant_delay = 4'd3;
   logic [31:0] rnd;
   integer      seed = 32'h36e8_7450;
   logic [3:0]  k;

   mif_reconfig_top uut (
      .reconfig_clk             (reconfig_clk),
      .rst_n                    (rst_n),
      .user_req                 (user_req),
      .mif_reconfig_readdata    (mif_reconfig_readdata),
      .mif_reconfig_waitrequest (mif_reconfig_waitrequest),
      .mif_reconfig_done        (mif_reconfig_done),
      .stream_req               (stream_req),
      .mif_stream_waitrequest   (mif_stream_waitrequest),
      .mif_stream_readdata      (mif_stream_readdata),
      .base_req                 (base_req),
      .mif_base_waitrequest     (mif_base_waitrequest),
      .arb_req                  (arb_req),
      .arb_grant                (arb_grant)
   );

   initial begin
      reconfig_clk = 1'b0;
      forever #4 reconfig_clk = ~reconfig_clk;
   end

   ////////////////////////////////////////
   // ROM, basic block and arbiter models
   ////////////////////////////////////////

   // One random draw per clock feeds all three models
   always @(posedge reconfig_clk) begin
      rnd = $random(seed);
      if (!rst_n) begin
         mif_stream_waitrequest <= 1'b1;
         mif_base_waitrequest   <= 1'b1;
         arb_grant              <= 1'b0;
         for (k = 4'd0; k < 4'd8; k = k + 4'd1) begin
            base_regs[k[2:0]] <= 32'hb0b0_0000 | {29'd0, k[2:0]};
         end
      end else begin
         // ROM word shows up with waitrequest low and stalls again after accept
         if (stream_req.read && mif_stream_waitrequest) begin
            if (rnd[1:0] != 2'b00) begin
               mif_stream_waitrequest <= 1'b0;
               mif_stream_readdata    <= rom[stream_req.address[5:0]];
            end
         end else if (stream_req.read) begin
            mif_stream_waitrequest <= 1'b1;
         end
         // Basic block register write
         if (base_req.write && mif_base_waitrequest) begin
            if (rnd[3:2] != 2'b00) begin
               mif_base_waitrequest <= 1'b0;
            end
         end else if (base_req.write) begin
            base_regs[base_req.address] <= base_req.writedata;
            write_count                 <= write_count + 1;
            mif_base_waitrequest        <= 1'b1;
         end
         // Grant after a random delay and kept while requested
         if (!arb_req) begin
            arb_grant   <= 1'b0;
            grant_wait  <= '0;
            grant_delay <= {1'b0, rnd[6:4]} + 4'd2;
         end else if (!arb_grant) begin
            if (grant_wait >= grant_delay) begin
               arb_grant <= 1'b1;
            end else begin
               grant_wait <= grant_wait + 4'd1;
            end
         end
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   task automatic fail_now();
      $display("Regression failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      fail_now();
   endtask

   task automatic check_value(input string name, input reg_data_t got, input reg_data_t exp);
      assert (got === exp) else begin
         $display("CHECK FAILED time=%0t signal=%s got=0x%08h expected=0x%08h",
                  $time, name, got, exp);
         fail_now();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("CHECK FAILED time=%0t signal=%s got=%b expected=%b",
                  $time, name, got, exp);
         fail_now();
      end
   endtask

   ////////////////////////////////////////
   // ROM image and expected results
   ////////////////////////////////////////

   task automatic put_word(inout logic [5:0] p, input mif_word_t w);
      rom[p] = w;
      p      = p + 6'd1;
   endtask

   // Header, low data word, high data word
   task automatic put_record(inout logic [5:0] p, input mif_word_t hdr, input reg_data_t data);
      put_word(p, hdr);
      put_word(p, data[15:0]);
      put_word(p, data[31:16]);
   endtask

   task automatic load_rom();
      logic [6:0] f;
      logic [5:0] p;
      for (f = 7'd0; f < 7'd64; f = f + 7'd1) begin
         rom[f[5:0]] = {4'h5, f[5:0], ~f[5:0]};
      end
      // Region at word 0 writes address 1 twice
      p = 6'd0;
      put_record(p, 16'h0001, 32'h1111_a001);
      put_record(p, 16'h3c04, 32'h4444_b004);
      put_record(p, 16'h0001, 32'h1212_c001);
      put_record(p, 16'h0007, 32'h7777_d007);
      put_word(p, 16'h80f3);
      // Region at word 16
      p = 6'd16;
      put_record(p, 16'h0002, 32'h2222_e002);
      put_record(p, 16'h0005, 32'h5555_f005);
      put_word(p, 16'h8005);
   endtask

   // Last write per address wins and records count up to the end header
   task automatic build_expected(input mif_addr_t addr);
      logic [5:0] p;
      mif_word_t  hdr;
      int         guard;
      logic       at_end;
      exp_regs  = base_regs;
      exp_count = 0;
      p         = addr[5:0];
      at_end    = 1'b0;
      for (guard = 0; guard < 32 && !at_end; guard++) begin
         hdr = rom[p];
         if (hdr[`REC_END_BIT]) begin
            at_end = 1'b1;
         end else begin
            exp_regs[hdr[`BASE_ADDR_W-1:0]] = {rom[p + 6'd2], rom[p + 6'd1]};
            exp_count++;
            p = p + 6'd3;
         end
      end
      if (!at_end) begin
         stop_with_failure("ROM region has no end header");
      end
   endtask

   ////////////////////////////////////////
   // User slave accesses
   ////////////////////////////////////////

   task automatic user_write(input base_addr_t a, input reg_data_t d);
      @(posedge reconfig_clk);
      user_req <= '{address: a, writedata: d, write: 1'b1, read: 1'b0};
      @(posedge reconfig_clk);
      user_req <= '0;
   endtask

   // Returns data and the number of wait cycles seen
   task automatic user_read(input base_addr_t a, output reg_data_t d, output int waits);
      int   guard;
      logic got;
      d     = '0;
      waits = 0;
      guard = 0;
      got   = 1'b0;
      @(posedge reconfig_clk);
      user_req <= '{address: a, writedata: '0, write: 1'b0, read: 1'b1};
      while (!got && guard < 16) begin
         @(negedge reconfig_clk);
         guard++;
         if (mif_reconfig_waitrequest) begin
            waits++;
         end else begin
            d   = mif_reconfig_readdata;
            got = 1'b1;
         end
      end
      if (!got) begin
         stop_with_failure("user read never completed");
      end
      @(posedge reconfig_clk);
      user_req <= '0;
   endtask

   ////////////////////////////////////////
   // Run control
   ////////////////////////////////////////

   task automatic wait_done_fall();
      int guard;
      guard = 0;
      while (mif_reconfig_done && guard < 8) begin
         @(negedge reconfig_clk);
         guard++;
      end
      if (mif_reconfig_done) begin
         stop_with_failure("done did not fall after start");
      end
   endtask

   // Run is past its first basic port write and still holds records
   task automatic wait_first_write(input int writes_before);
      int guard;
      guard = 0;
      while (write_count == writes_before && guard < 2000) begin
         @(negedge reconfig_clk);
         guard++;
      end
      if (write_count == writes_before) begin
         stop_with_failure("no basic port write during the run");
      end
   endtask

   // arb_req must rise once and stay up until the run ends
   task automatic wait_run_end();
      int   guard;
      logic req_seen;
      logic req_dropped;
      guard       = 0;
      req_seen    = 1'b0;
      req_dropped = 1'b0;
      while (!mif_reconfig_done && guard < 4000) begin
         if (arb_req) begin
            assert (!req_dropped) else stop_with_failure("arb_req rose twice in one run");
            req_seen = 1'b1;
         end else if (req_seen) begin
            req_dropped = 1'b1;
         end
         @(negedge reconfig_clk);
         guard++;
      end
      if (!mif_reconfig_done) begin
         stop_with_failure("done never returned");
      end
      assert (req_seen) else stop_with_failure("arb_req never rose during the run");
      check_bit("arb_req", arb_req, 1'b0);
   endtask

   task automatic run_mif(input mif_addr_t addr, input logic restart_mid);
      reg_data_t rd;
      int        waits;
      int        writes_before;
      logic [3:0] i;
      build_expected(addr);
      writes_before = write_count;
      user_write(`REG_START, addr);
      user_write(`REG_CTRL, 32'h1);
      wait_done_fall();
      // Go written while busy must change nothing
      if (restart_mid) begin
         wait_first_write(writes_before);
         user_write(`REG_CTRL, 32'h1);
      end
      wait_run_end();
      for (i = 4'd0; i < 4'd8; i = i + 4'd1) begin
         check_value($sformatf("base_regs[%0d]", i), base_regs[i[2:0]], exp_regs[i[2:0]]);
      end
      check_value("basic port writes", reg_data_t'(write_count - writes_before),
                  reg_data_t'(exp_count));
      user_read(`REG_COUNT, rd, waits);
      check_value("REG_COUNT", rd, reg_data_t'(exp_count));
      check_value("mif_reconfig_waitrequest cycles", reg_data_t'(waits), 32'd1);
      user_read(`REG_STATUS, rd, waits);
      check_value("REG_STATUS", rd, 32'd0);
      user_read(`REG_START, rd, waits);
      check_value("REG_START", rd, addr);
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      user_req = '0;
      rst_n    = 1'b0;
      load_rom();
      repeat (5) @(posedge reconfig_clk);
      rst_n <= 1'b1;
      @(negedge reconfig_clk);
      check_bit("mif_reconfig_done", mif_reconfig_done, 1'b1);
      check_bit("mif_stream_read", stream_req.read, 1'b0);
      check_bit("mif_base_write", base_req.write, 1'b0);
      check_bit("arb_req", arb_req, 1'b0);
      check_bit("mif_reconfig_waitrequest", mif_reconfig_waitrequest, 1'b0);
      // Four records from word 0 then two from word 16
      run_mif(32'd0, 1'b0);
      run_mif(32'd16, 1'b1);
      $display("Regression passed");
      $finish;
   end

endmodule

/* verilog/mif_base_writer.sv */
/*
 * Basic port write master of the MIF engine.
 * Buffers one record, holds the arbiter for the whole run, writes once granted.
 */
`timescale 1ns/1ps

module mif_base_writer
   import mif_bus_pkg::*;
(
   input  logic        reconfig_clk,
   input  logic        rst_n,
   input  logic        start,
   input  mif_record_s rec,
   input  logic        rec_valid,
   output logic        rec_ready,
   input  logic        end_seen,
   output base_req_s   base_req,
   input  logic        mif_base_waitrequest,
   output logic        arb_req,
   input  logic        arb_grant,
   output logic        busy,
   output logic        rec_written
);

   logic        busy_q;
   logic        end_pend_q;
   logic        buf_valid_q;
   mif_record_s buf_q;
   logic        wr;
   logic        wr_done;

   // Arbiter keeps grant while req stays high
   assign wr      = buf_valid_q && arb_grant;
   assign wr_done = wr && !mif_base_waitrequest;

   ////////////////////////////////////////
   // Run and buffer control
   ////////////////////////////////////////

   always_ff @(posedge reconfig_clk) begin
      if (!rst_n) begin
         busy_q      <= 1'b0;
         end_pend_q  <= 1'b0;
         buf_valid_q <= 1'b0;
      end else begin
         if (start) begin
            busy_q     <= 1'b1;
            end_pend_q <= 1'b0;
         end else if (busy_q && end_pend_q && !buf_valid_q) begin
            // End parsed and last write done
            busy_q <= 1'b0;
         end
         if (end_seen) begin
            end_pend_q <= 1'b1;
         end
         // Load only arrives on an empty buffer
         if (rec_valid) begin
            buf_valid_q <= 1'b1;
         end else if (wr_done) begin
            buf_valid_q <= 1'b0;
         end
      end
   end

   // Record payload
   always_ff @(posedge reconfig_clk) begin
      if (rec_valid && !buf_valid_q) begin
         buf_q <= rec;
      end
   end

   assign base_req    = '{address: buf_q.base_addr, writedata: buf_q.data, write: wr};
   assign rec_ready   = !buf_valid_q;
   assign rec_written = wr_done;
   // Request spans the whole run
   assign arb_req     = busy_q;
   assign busy        = busy_q;

endmodule

/* verilog/mif_bus_pkg.sv */
/*
 * Packed structs carried between the engine blocks and on its ports.
 * Import with a wildcard in the module header.
 */
package mif_bus_pkg;

   import mif_types_pkg::*;

   // One parsed MIF record
   typedef struct packed {
      base_addr_t base_addr;
      reg_data_t  data;
   } mif_record_s;

   // Basic block write master
   typedef struct packed {
      base_addr_t address;
      reg_data_t  writedata;
      logic       write;
   } base_req_s;

   // User register slave access
   typedef struct packed {
      base_addr_t address;
      reg_data_t  writedata;
      logic       write;
      logic       read;
   } user_req_s;

   // ROM streaming read
   // Held by the master while waitrequest is high
   typedef struct packed {
      mif_addr_t address;
      logic      read;
   } stream_req_s;

endpackage

/* verilog/mif_reconfig_top.sv */
/*
 * Top level of the MIF reconfiguration engine.
 * Connects user slave, ROM stream reader and basic port writer.
 */
`timescale 1ns/1ps

module mif_reconfig_top
   import mif_types_pkg::*;
   import mif_bus_pkg::*;
(
   input  logic        reconfig_clk,
   input  logic        rst_n,
   // User slave
   input  user_req_s   user_req,
   output reg_data_t   mif_reconfig_readdata,
   output logic        mif_reconfig_waitrequest,
   output logic        mif_reconfig_done,
   // ROM stream
   output stream_req_s stream_req,
   input  logic        mif_stream_waitrequest,
   input  mif_word_t   mif_stream_readdata,
   // Basic port
   output base_req_s   base_req,
   input  logic        mif_base_waitrequest,
   // Arbiter
   output logic        arb_req,
   input  logic        arb_grant
);

   logic        start;
   mif_addr_t   start_addr;
   logic        busy;
   logic        rec_written;
   mif_record_s rec;
   logic        rec_valid;
   logic        rec_ready;
   logic        end_seen;

   ////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////

   mif_user_regs u_regs (
      .reconfig_clk             (reconfig_clk),
      .rst_n                    (rst_n),
      .user_req                 (user_req),
      .mif_reconfig_readdata    (mif_reconfig_readdata),
      .mif_reconfig_waitrequest (mif_reconfig_waitrequest),
      .mif_reconfig_done        (mif_reconfig_done),
      .start                    (start),
      .start_addr               (start_addr),
      .busy                     (busy),
      .rec_written              (rec_written)
   );

   // Parses ROM words into records
   mif_stream_reader u_reader (
      .reconfig_clk           (reconfig_clk),
      .rst_n                  (rst_n),
      .start                  (start),
      .start_addr             (start_addr),
      .stream_req             (stream_req),
      .mif_stream_waitrequest (mif_stream_waitrequest),
      .mif_stream_readdata    (mif_stream_readdata),
      .rec                    (rec),
      .rec_valid              (rec_valid),
      .rec_ready              (rec_ready),
      .end_seen               (end_seen)
   );

   // Writes records under arbiter grant
   mif_base_writer u_writer (
      .reconfig_clk         (reconfig_clk),
      .rst_n                (rst_n),
      .start                (start),
      .rec                  (rec),
      .rec_valid            (rec_valid),
      .rec_ready            (rec_ready),
      .end_seen             (end_seen),
      .base_req             (base_req),
      .mif_base_waitrequest (mif_base_waitrequest),
      .arb_req              (arb_req),
      .arb_grant            (arb_grant),
      .busy                 (busy),
      .rec_written          (rec_written)
   );

endmodule

/* verilog/mif_stream_reader.sv */
/*
 * ROM streaming master of the MIF engine.
 * Walks word addresses from the start address and builds records of
 * header, low and high words for the basic port writer.
 */
`timescale 1ns/1ps
`include "mif_params.svh"

module mif_stream_reader
   import mif_types_pkg::*;
   import mif_bus_pkg::*;
(
   input  logic        reconfig_clk,
   input  logic        rst_n,
   input  logic        start,
   input  mif_addr_t   start_addr,
   output stream_req_s stream_req,
   input  logic        mif_stream_waitrequest,
   input  mif_word_t   mif_stream_readdata,
   output mif_record_s rec,
   output logic        rec_valid,
   input  logic        rec_ready,
   output logic        end_seen
);

   stream_state_e state_q;
   mif_addr_t     addr_q;
   mif_record_s   rec_q;
   logic          rd;
   logic          word_ok;
   logic          is_end;

   // Read held through every fetch state
   assign rd      = (state_q == fetch_header) || (state_q == fetch_low) ||
                    (state_q == fetch_high);
   // Word accepted this cycle
   assign word_ok = rd && !mif_stream_waitrequest;
   assign is_end  = mif_stream_readdata[`REC_END_BIT];

   ////////////////////////////////////////
   // Reader FSM
   ////////////////////////////////////////

   always_ff @(posedge reconfig_clk) begin
      if (!rst_n) begin
         state_q <= idle;
      end else begin
         case (state_q)
            idle: begin
               if (start) begin
                  state_q <= fetch_header;
               end
            end
            fetch_header: begin
               // End header carries no data words
               if (word_ok) begin
                  state_q <= is_end ? finish : fetch_low;
               end
            end
            fetch_low: begin
               if (word_ok) begin
                  state_q <= fetch_high;
               end
            end
            fetch_high: begin
               if (word_ok) begin
                  state_q <= hand_off;
               end
            end
            hand_off: begin
               // Wait for the writer buffer to drain
               if (rec_ready) begin
                  state_q <= fetch_header;
               end
            end
            finish: begin
               state_q <= idle;
            end
            default: begin
               state_q <= idle;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Address walk and record assembly
   ////////////////////////////////////////

   always_ff @(posedge reconfig_clk) begin
      if (start && (state_q == idle)) begin
         addr_q <= start_addr;
      end else if (word_ok) begin
         addr_q <= addr_q + mif_addr_t'(1);
      end
      if (word_ok) begin
         case (state_q)
            fetch_header: rec_q.base_addr <= mif_stream_readdata[`BASE_ADDR_W-1:0];
            fetch_low:    rec_q.data[`MIF_WORD_W-1:0] <= mif_stream_readdata;
            fetch_high:   rec_q.data[`REG_DATA_W-1:`MIF_WORD_W] <= mif_stream_readdata;
            default:      rec_q <= rec_q;
         endcase
      end
   end

   assign stream_req = '{address: addr_q, read: rd};
   assign rec        = rec_q;
   // Leaves hand_off in the same cycle, so one pulse per record
   assign rec_valid  = (state_q == hand_off) && rec_ready;
   assign end_seen   = (state_q == finish);

endmodule

/* verilog/mif_types_pkg.sv */
/*
 * Plain width types and FSM encodings shared by the engine blocks.
 * Import with a wildcard in the module header.
 */
`include "mif_params.svh"

package mif_types_pkg;

   ////////////////////////////////////////
   // Widths that carry a meaning
   ////////////////////////////////////////

   // One ROM word
   typedef logic [`MIF_WORD_W-1:0]  mif_word_t;
   // ROM word address
   typedef logic [`MIF_ADDR_W-1:0]  mif_addr_t;
   // Basic block register address
   typedef logic [`BASE_ADDR_W-1:0] base_addr_t;
   // Register data on both slave ports
   typedef logic [`REG_DATA_W-1:0]  reg_data_t;
   // Records written per run
   typedef logic [`REC_CNT_W-1:0]   rec_count_t;

   ////////////////////////////////////////
   // FSM encodings
   ////////////////////////////////////////

   // ROM reader
   typedef enum logic [2:0] {
      idle,
      fetch_header,
      fetch_low,
      fetch_high,
      hand_off,
      finish
   } stream_state_e;

endpackage

/* verilog/mif_user_regs.sv */
/*
 * User register slave of the MIF engine.
 * Holds start address and record count, issues the start pulse, drives done.
 */
`timescale 1ns/1ps
`include "mif_params.svh"

module mif_user_regs
   import mif_types_pkg::*;
   import mif_bus_pkg::*;
(
   input  logic        reconfig_clk,
   input  logic        rst_n,
   input  user_req_s   user_req,
   output reg_data_t   mif_reconfig_readdata,
   output logic        mif_reconfig_waitrequest,
   output logic        mif_reconfig_done,
   output logic        start,
   output mif_addr_t   start_addr,
   input  logic        busy,
   input  logic        rec_written
);

   logic        ctrl_go;
   logic        start_q;
   logic        done_q;
   logic        rd_done_q;
   mif_addr_t   start_addr_q;
   rec_count_t  count_q;
   reg_data_t   rdata_q;

   // Go bit written to the control register
   assign ctrl_go = user_req.write && (user_req.address == `REG_CTRL) &&
                    user_req.writedata[0];

   ////////////////////////////////////////
   // Control state
   ////////////////////////////////////////

   always_ff @(posedge reconfig_clk) begin
      if (!rst_n) begin
         start_q      <= 1'b0;
         done_q       <= 1'b1;
         rd_done_q    <= 1'b0;
         start_addr_q <= '0;
         count_q      <= '0;
      end else begin
         // Single pulse, dropped while a run is active
         start_q   <= ctrl_go && !busy && !start_q;
         // Low from the cycle after start until busy clears
         done_q    <= !busy && !start_q;
         // Second cycle of a read ends the wait
         rd_done_q <= user_req.read && !rd_done_q;
         if (user_req.write && (user_req.address == `REG_START)) begin
            start_addr_q <= user_req.writedata;
         end
         // Count restarts with every run
         if (start_q) begin
            count_q <= '0;
         end else if (rec_written) begin
            count_q <= count_q + rec_count_t'(1);
         end
      end
   end

   ////////////////////////////////////////
   // Read path
   ////////////////////////////////////////

   // Captured in the wait cycle, presented in the next one
   always_ff @(posedge reconfig_clk) begin
      if (user_req.read && !rd_done_q) begin
         case (user_req.address)
            `REG_START:  rdata_q <= start_addr_q;
            `REG_STATUS: rdata_q <= {{(`REG_DATA_W-1){1'b0}}, busy};
            `REG_COUNT:  rdata_q <= {{(`REG_DATA_W-`REC_CNT_W){1'b0}}, count_q};
            // Control reads back as zero
            default:     rdata_q <= '0;
         endcase
      end
   end

   assign mif_reconfig_waitrequest = user_req.read && !rd_done_q;
   assign mif_reconfig_readdata    = rdata_q;
   assign mif_reconfig_done        = done_q;
   assign start                    = start_q;
   assign start_addr               = start_addr_q;

endmodule

/* xcvr_mif_reconfig.f */
+incdir+include
verilog/mif_types_pkg.sv
verilog/mif_bus_pkg.sv
verilog/mif_user_regs.sv
verilog/mif_stream_reader.sv
verilog/mif_base_writer.sv
verilog/mif_reconfig_top.sv
tests/mif_reconfig_chk.sv
tests/tb_mif_reconfig.sv
